/* sim.f */
hw/ex_pkg.sv
hw/ex_operands.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_stage.sv
sim/tb_ex_sva.sv
sim/tb_ex.sv

/* run.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it and judge the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_ex -f sim.f -o tb_ex_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_ex_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0

/* sim/tb_ex.sv */
// testbench for the execute stage, issues instructions and checks results against a model
`timescale 1ns/1ns
`default_nettype none

module tb_ex
    import ex_pkg::*;
();

    localparam int N_ALU = 64;
    localparam int N_FWD = 6;
    localparam int N_BRJ = 22;
    localparam int N_MUL = 24;
    localparam int N_X0  = 5;
    localparam int N_ALL = N_ALU + N_FWD + N_BRJ + N_MUL + N_X0 + 8;  // slack for reset
    localparam logic [XLEN-1:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

    logic            clk_i;
    logic            reset_i;
    ex_issue_t       issue_i;
    bypass_t         bypass_i;
    logic            ready_o;
    logic            jump_flag_o;
    logic [XLEN-1:0] jump_addr_o;
    wb_t             wb_o;

    integer          seed       = 76;
    int              err_count  = 0;
    int              mon_errs   = 0;
    int              mon_idx    = 0;
    int              test_base  = 0;
    int              tests_pass = 0;
    int              tests_fail = 0;
    string           cur_test   = "reset";
    wb_t             exp_q[$];
    logic [XLEN-1:0] exp_res;
    logic [XLEN-1:0] exp_ja;
    logic            exp_we;
    logic            exp_jf;

    ex_stage #(
        .MULT_STEP_BITS(2)
    ) dut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .issue_i    (issue_i),
        .bypass_i   (bypass_i),
        .ready_o    (ready_o),
        .jump_flag_o(jump_flag_o),
        .jump_addr_o(jump_addr_o),
        .wb_o       (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic void show_value(input string what, input logic [31:0] exp_v,
                                       input logic [31:0] act_v);
        $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
    endfunction

    function automatic void show_text(input string msg);
        $display("[ERROR] %s: %s", cur_test, msg);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // register addresses come from the instruction fields
    function automatic ex_issue_t make_inst(input logic [XLEN-1:0] inst,
                                            input logic [XLEN-1:0] pc,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
        ex_issue_t ins;
        ins.inst      = inst;
        ins.inst_addr = pc;
        ins.rs1_addr  = inst[19:15];
        ins.rs1_data  = a;
        ins.rs2_addr  = inst[24:20];
        ins.rs2_data  = b;
        ins.rd_addr   = inst[11:7];
        return ins;
    endfunction

    // reference model of the stage
    function automatic void predict(input ex_issue_t ins, input bypass_t byp);
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] imm_u;
        logic [4:0]      sh;
        logic [63:0]     prod;
        logic [2:0]      f3;
        inst  = ins.inst;
        f3    = inst[14:12];
        a     = (byp.wen && byp.waddr != 0 && byp.waddr == ins.rs1_addr) ? byp.wdata
                                                                         : ins.rs1_data;
        b     = (byp.wen && byp.waddr != 0 && byp.waddr == ins.rs2_addr) ? byp.wdata
                                                                         : ins.rs2_data;
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        x     = (inst[6:0] == OP) ? b : imm_i;
        sh    = x[4:0];  // shamt sits in the low immediate bits
        exp_res = '0;
        exp_we  = 1'b0;
        exp_jf  = 1'b0;
        exp_ja  = '0;
        case (inst[6:0])
            OP_IMM, OP: begin
                exp_we = 1'b1;
                if (inst[6:0] == OP && inst[31:25] == FUNCT7_MULDIV) begin
                    case (f3)
                        3'b000, 3'b001: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                        3'b010:         prod = {{32{a[31]}}, a} * {32'h0, b};
                        default:        prod = {32'h0, a} * {32'h0, b};
                    endcase
                    exp_res = (f3 == 3'b000) ? prod[31:0] : prod[63:32];
                end else begin
                    case (f3)
                        3'b000:  exp_res = (inst[6:0] == OP && inst[30]) ? a - x : a + x;
                        3'b001:  exp_res = a << sh;
                        3'b010:  exp_res = {31'h0, $signed(a) < $signed(x)};
                        3'b011:  exp_res = {31'h0, a < x};
                        3'b100:  exp_res = a ^ x;
                        3'b101: begin
                            if (inst[30]) exp_res = $signed(a) >>> sh;
                            else          exp_res = a >> sh;
                        end
                        3'b110:  exp_res = a | x;
                        default: exp_res = a & x;
                    endcase
                end
            end
            BRANCH: begin
                case (f3)
                    3'b000:  exp_jf = (a == b);
                    3'b001:  exp_jf = (a != b);
                    3'b100:  exp_jf = ($signed(a) < $signed(b));
                    3'b101:  exp_jf = ($signed(a) >= $signed(b));
                    3'b110:  exp_jf = (a < b);
                    default: exp_jf = (a >= b);
                endcase
                if (exp_jf) exp_ja = ins.inst_addr + imm_b;
            end
            JAL: begin
                exp_we  = 1'b1;
                exp_res = ins.inst_addr + 32'd4;
                exp_jf  = 1'b1;
                exp_ja  = ins.inst_addr + imm_j;
            end
            JALR: begin
                exp_we  = 1'b1;
                exp_res = ins.inst_addr + 32'd4;
                exp_jf  = 1'b1;
                exp_ja  = (a + imm_i) & ~32'h1;
            end
            LUI: begin
                exp_we  = 1'b1;
                exp_res = imm_u;
            end
            AUIPC: begin
                exp_we  = 1'b1;
                exp_res = ins.inst_addr + imm_u;
            end
            default: ;
        endcase
        if (ins.rd_addr == 0) exp_we = 1'b0;
    endfunction

    // entered a few ns after a rising edge, returns likewise
    task automatic run_inst(input ex_issue_t ins, input bypass_t byp);
        wb_t  e;
        logic mul;
        mul      = (ins.inst[6:0] == OP) && (ins.inst[31:25] == FUNCT7_MULDIV);
        issue_i  = ins;
        bypass_i = byp;
        predict(ins, byp);
        @(negedge clk_i);
        assert (ready_o == !mul) else begin
            show_value("ready_o first cycle", 32'(!mul), 32'(ready_o));
            err_count++;
        end
        while (!ready_o) @(negedge clk_i);  // watchdog bounds this
        assert (jump_flag_o == exp_jf) else begin
            show_value("jump_flag_o", 32'(exp_jf), 32'(jump_flag_o));
            err_count++;
        end
        assert (jump_addr_o == exp_ja) else begin
            show_value("jump_addr_o", exp_ja, jump_addr_o);
            err_count++;
        end
        @(posedge clk_i);
        #5;
        if (exp_we) begin
            e.we    = 1'b1;
            e.waddr = ins.rd_addr;
            e.wdata = exp_res;
            exp_q.push_back(e);
        end
        issue_i  = make_inst(NOP, '0, '0, '0);
        bypass_i = '0;
    endtask

    task automatic forward_case(input logic [4:0] rs1, input logic [4:0] rs2,
                                input logic wen, input logic [4:0] waddr);
        bypass_t byp;
        byp.wen   = wen;
        byp.waddr = waddr;
        byp.wdata = $random(seed);
        run_inst(make_inst(r_type(7'h20, rs2, rs1, 3'b000, 5'd3), 32'h100,
                           $random(seed), $random(seed)), byp);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = err_count + mon_errs;
    endtask

    task automatic finish_test();
        int errs;
        repeat (2) @(negedge clk_i);
        assert (mon_idx == exp_q.size()) else begin
            show_text("an expected writeback never appeared");
            err_count++;
        end
        errs = err_count + mon_errs - test_base;
        if (errs == 0) begin
            tests_pass++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_fail++;
            $display("test %s: %0d errors", cur_test, errs);
        end
        @(posedge clk_i);
        #5;
    endtask

    // writebacks arrive in issue order
    always @(negedge clk_i) begin
        if (!reset_i && wb_o.we) begin
            if (mon_idx >= exp_q.size()) begin
                show_text("writeback seen while none was expected");
                mon_errs++;
            end else begin
                assert (wb_o.waddr == exp_q[mon_idx].waddr) else begin
                    show_value("wb_o.waddr", 32'(exp_q[mon_idx].waddr), 32'(wb_o.waddr));
                    mon_errs++;
                end
                assert (wb_o.wdata == exp_q[mon_idx].wdata) else begin
                    show_value("wb_o.wdata", exp_q[mon_idx].wdata, wb_o.wdata);
                    mon_errs++;
                end
                mon_idx++;
            end
        end
    end

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        logic [11:0]     imm;
        logic [12:0]     boff;
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic [6:0]      f7;
        logic [XLEN-1:0] inst;
        reset_i  = 1'b1;
        issue_i  = make_inst(NOP, '0, '0, '0);
        bypass_i = '0;
        repeat (3) @(posedge clk_i);
        #5;
        reset_i = 1'b0;

        start_test("quiet_after_reset");
        @(negedge clk_i);
        assert (!wb_o.we && !jump_flag_o && ready_o) else begin
            show_value("{we, jump, ready}", 32'h1, {29'h0, wb_o.we, jump_flag_o, ready_o});
            err_count++;
        end
        finish_test();

        start_test("alu_random");
        for (int i = 0; i < N_ALU; i++) begin
            f3 = i[2:0];
            rd = 5'(i % 31 + 1);
            a  = $random(seed);
            b  = $random(seed);
            pc = $random(seed);
            pc[1:0] = 2'b00;
            if (i[3]) begin
                f7   = (i[4] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                inst = r_type(f7, 5'd2, 5'd1, f3, rd);
            end else begin
                imm = 12'($random(seed));
                if (f3 == 3'b001) imm[11:5] = 7'h00;
                if (f3 == 3'b101) imm[11:5] = i[4] ? 7'h20 : 7'h00;  // srai or srli
                inst = i_type(imm, 5'd1, f3, rd, OP_IMM);
            end
            run_inst(make_inst(inst, pc, a, b), '0);
        end
        finish_test();

        start_test("forwarding");
        forward_case(5'd1, 5'd2, 1'b1, 5'd1);
        forward_case(5'd1, 5'd2, 1'b1, 5'd2);
        forward_case(5'd5, 5'd5, 1'b1, 5'd5);
        forward_case(5'd0, 5'd2, 1'b1, 5'd0);
        forward_case(5'd1, 5'd2, 1'b1, 5'd7);
        forward_case(5'd1, 5'd2, 1'b0, 5'd1);
        finish_test();

        start_test("branch_jump_upper");
        for (int j = 0; j < 6; j++) begin
            f3 = (j < 2) ? 3'(j) : 3'(j + 2);
            for (int p = 0; p < 3; p++) begin
                boff = 13'($random(seed));
                boff[0] = 1'b0;
                pc = $random(seed);
                pc[1:0] = 2'b00;
                a = (p == 1) ? 32'hFFFF_FFFB : (p == 2) ? 32'd3 : 32'h1234_5678;
                b = (p == 1) ? 32'd3 : (p == 2) ? 32'hFFFF_FFFB : 32'h1234_5678;
                run_inst(make_inst(b_type(boff, 5'd2, 5'd1, f3), pc, a, b), '0);
            end
        end
        a = $random(seed);
        run_inst(make_inst(j_type({a[20:1], 1'b0}, 5'd1), pc, '0, '0), '0);
        run_inst(make_inst(i_type(12'($random(seed)), 5'd1, 3'b000, 5'd5, JALR), pc,
                           $random(seed), '0), '0);
        run_inst(make_inst(u_type(20'($random(seed)), 5'd6, LUI), pc, '0, '0), '0);
        run_inst(make_inst(u_type(20'($random(seed)), 5'd7, AUIPC), pc, '0, '0), '0);
        finish_test();

        start_test("multiply");
        for (int i = 0; i < N_MUL; i++) begin
            a = $random(seed);
            b = $random(seed);
            if ((i >= 4 && i < 8) || (i >= 12 && i < 16)) a = 32'h8000_0000;  // most negative
            if (i >= 8 && i < 16) b = 32'h8000_0000;
            rd = 5'(i % 31 + 1);
            run_inst(make_inst(r_type(FUNCT7_MULDIV, 5'd2, 5'd1, 3'(i % 4), rd), pc, a, b),
                     '0);
        end
        finish_test();

        start_test("x0_no_write");
        run_inst(make_inst(i_type(12'h123, 5'd1, 3'b000, 5'd0, OP_IMM), pc, 32'h5, '0), '0);
        run_inst(make_inst(r_type(FUNCT7_MULDIV, 5'd2, 5'd1, 3'b000, 5'd0), pc,
                           32'h7, 32'h9), '0);
        run_inst(make_inst(j_type(21'h00100, 5'd0), pc, '0, '0), '0);
        run_inst(make_inst(u_type(20'hABCDE, 5'd0, LUI), pc, '0, '0), '0);
        run_inst(make_inst(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd0), pc, 32'h9, 32'h2), '0);
        finish_test();

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_pass, tests_fail, err_count + mon_errs);
        if (tests_fail == 0 && err_count + mon_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (N_ALL * 20) @(posedge clk_i);
        $display("timeout: tests still running after %0d cycles", N_ALL * 20);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_ex_sva.sv */
// concurrent checks on writeback, jump outputs and stall length, bound into every ex_stage
`timescale 1ns/1ns
`default_nettype none

module ex_stage_sva
    import ex_pkg::*;
#(
    parameter int MULT_STEP_BITS = 2
) (
    input logic            clk_i,
    input logic            reset_i,
    input logic            ready_i,
    input logic            jump_flag_i,
    input logic [XLEN-1:0] jump_addr_i,
    input wb_t             wb_i
);

    localparam int STALL_MAX = XLEN / MULT_STEP_BITS + 4;

    int stall_cnt;  // consecutive cycles with ready low

    always_ff @(posedge clk_i) begin
        if (reset_i || ready_i) stall_cnt <= 0;
        else                    stall_cnt <= stall_cnt + 1;
    end

    wb_quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> !wb_i.we)
        else $error("writeback enable high right after reset");

    wb_never_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_i.we |-> (wb_i.waddr != '0))
        else $error("writeback to register zero");

    // target must be cleared when no jump
    jump_addr_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        !jump_flag_i |-> (jump_addr_i == '0))
        else $error("jump address nonzero without jump flag");

    stall_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
        stall_cnt <= STALL_MAX)
        else $error("ready stayed low longer than the multiply latency allows");

endmodule

bind ex_stage ex_stage_sva #(
    .MULT_STEP_BITS(MULT_STEP_BITS)
) u_sva (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ready_i    (ready_o),
    .jump_flag_i(jump_flag_o),
    .jump_addr_i(jump_addr_o),
    .wb_i       (wb_o)
);

`default_nettype wire

/* hw/ex_stage.sv */
// execute stage top, joins operand select, alu and multiplier and registers the writeback
`timescale 1ns/1ns
`default_nettype none

module ex_stage
    import ex_pkg::*;
#(
    parameter int MULT_STEP_BITS = 2
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  ex_issue_t       issue_i,
    input  bypass_t         bypass_i,
    output logic            ready_o,
    output logic            jump_flag_o,
    output logic [XLEN-1:0] jump_addr_o,
    output wb_t             wb_o
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  is_mul;
    operands_t             ops;
    logic [XLEN-1:0]       alu_result;
    logic                  alu_we;
    logic [XLEN-1:0]       mult_result;
    logic                  mult_ready;
    logic                  wr_en;
    logic [XLEN-1:0]       wr_data;
    logic                  wb_we_q;
    logic [REG_ADDR_W-1:0] wb_waddr_q;
    logic [XLEN-1:0]       wb_wdata_q;

    ex_operands u_operands (
        .issue_i (issue_i),
        .bypass_i(bypass_i),
        .opcode_o(opcode),
        .funct3_o(funct3),
        .is_mul_o(is_mul),
        .ops_o   (ops)
    );

    ex_alu u_alu (
        .opcode_i   (opcode),
        .funct3_i   (funct3),
        .inst_i     (issue_i.inst),
        .inst_addr_i(issue_i.inst_addr),
        .ops_i      (ops),
        .result_o   (alu_result),
        .we_o       (alu_we),
        .jump_flag_o(jump_flag_o),
        .jump_addr_o(jump_addr_o)
    );

    ex_mult #(
        .MULT_STEP_BITS(MULT_STEP_BITS)
    ) u_mult (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .op_i          (mul_f3_e'(funct3)),
        .valid_i       (is_mul),
        .multiplicand_i(ops.op1),
        .multiplier_i  (ops.op2),
        .result_o      (mult_result),
        .ready_o       (mult_ready)
    );

    assign ready_o = ~is_mul | mult_ready;  // stall while the product is pending
    assign wr_data = is_mul ? mult_result : alu_result;
    assign wr_en   = (is_mul ? mult_ready : alu_we) && (|issue_i.rd_addr);  // no x0 writes

    always_ff @(posedge clk_i) begin
        if (reset_i) wb_we_q <= 1'b0;
        else         wb_we_q <= wr_en;
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            wb_waddr_q <= issue_i.rd_addr;
            wb_wdata_q <= wr_data;
        end
    end

    assign wb_o = '{we: wb_we_q, waddr: wb_waddr_q, wdata: wb_wdata_q};

endmodule

`default_nettype wire

/* hw/ex_mult.sv */
// iterative shift-add multiplier for mul, mulh, mulhsu and mulhu with a valid/ready handshake
`timescale 1ns/1ns
`default_nettype none

module ex_mult
    import ex_pkg::*;
#(
    parameter int MULT_STEP_BITS = 2
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  mul_f3_e         op_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] multiplicand_i,
    input  logic [XLEN-1:0] multiplier_i,
    output logic [XLEN-1:0] result_o,
    output logic            ready_o
);

    localparam int STEPS = XLEN / MULT_STEP_BITS;
    localparam int CNT_W = $clog2(STEPS + 1);

    mult_state_e         state_q;
    logic [CNT_W-1:0]    count_q;
    mul_f3_e             op_q;
    logic                neg_q;
    logic [2*XLEN-1:0]   mcand_q;
    logic [XLEN-1:0]     mplier_q;
    logic [2*XLEN-1:0]   prod_q;
    logic [2*XLEN-1:0]   partial;
    logic [2*XLEN-1:0]   signed_prod;
    logic                a_neg;
    logic                b_neg;
    logic [XLEN-1:0]     abs_a;
    logic [XLEN-1:0]     abs_b;

    // rs1 is signed except for mulhu, rs2 only for mul and mulh
    always_comb begin
        a_neg = multiplicand_i[XLEN-1] && (op_i != MULHU);
        b_neg = multiplier_i[XLEN-1] && (op_i == MUL || op_i == MULH);
        abs_a = a_neg ? -multiplicand_i : multiplicand_i;
        abs_b = b_neg ? -multiplier_i : multiplier_i;
    end

    always_comb begin
        partial = '0;
        for (int j = 0; j < MULT_STEP_BITS; j++) begin
            if (mplier_q[j]) partial = partial + (mcand_q << j);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: if (valid_i) begin
                    state_q <= BUSY;
                    count_q <= '0;
                end
                BUSY: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_W'(STEPS - 1)) state_q <= DONE;
                end
                default: state_q <= IDLE;  // one-cycle result pulse
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && valid_i) begin
            op_q     <= op_i;
            neg_q    <= a_neg ^ b_neg;
            mcand_q  <= {{XLEN{1'b0}}, abs_a};
            mplier_q <= abs_b;
            prod_q   <= '0;
        end else if (state_q == BUSY) begin
            prod_q   <= prod_q + partial;
            mcand_q  <= mcand_q << MULT_STEP_BITS;
            mplier_q <= mplier_q >> MULT_STEP_BITS;
        end
    end

    assign signed_prod = neg_q ? -prod_q : prod_q;
    assign result_o    = (op_q == MUL) ? signed_prod[XLEN-1:0] : signed_prod[2*XLEN-1:XLEN];
    assign ready_o     = (state_q == DONE);

endmodule

`default_nettype wire

/* hw/ex_alu.sv */
// single-cycle integer datapath with branch compare and jump target generation
`timescale 1ns/1ns
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  opcode_e         opcode_i,
    input  logic [2:0]      funct3_i,
    input  logic [XLEN-1:0] inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  operands_t       ops_i,
    output logic [XLEN-1:0] result_o,
    output logic            we_o,
    output logic            jump_flag_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [4:0]      shamt;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic [XLEN-1:0] cmp_a;
    logic [XLEN-1:0] cmp_b;
    logic            lt_s;
    logic            lt_u;
    logic            eq;
    logic [XLEN-1:0] link_addr;
    logic            take;
    logic [XLEN-1:0] target;

    always_comb begin
        op1       = ops_i.op1;
        op2       = ops_i.op2;
        sum       = op1 + op2;
        diff      = op1 - op2;
        link_addr = inst_addr_i + XLEN'(4);
    end

    // shamt from rs2 or the low I immediate bits
    always_comb begin
        shamt   = op2[4:0];
        sll_res = op1 << shamt;
        srl_res = op1 >> shamt;
        sra_res = $signed(op1) >>> shamt;  // fills with op1[31]
    end

    // branches compare the registers, slt/slti compare the operands
    always_comb begin
        cmp_a = (opcode_i == BRANCH) ? ops_i.rs1_val : op1;
        cmp_b = (opcode_i == BRANCH) ? ops_i.rs2_val : op2;
        lt_s  = $signed(cmp_a) < $signed(cmp_b);
        lt_u  = cmp_a < cmp_b;
        eq    = cmp_a == cmp_b;
    end

    always_comb begin
        result_o = '0;
        we_o     = 1'b0;
        take     = 1'b0;
        target   = sum;
        case (opcode_i)
            OP_IMM, OP: begin
                we_o = 1'b1;  // mul writes are sorted out by the stage
                case (alu_f3_e'(funct3_i))
                    ADD_SUB: result_o = (opcode_i == OP && inst_i[30]) ? diff : sum;
                    SLL:     result_o = sll_res;
                    SLT:     result_o = {{(XLEN-1){1'b0}}, lt_s};
                    SLTU:    result_o = {{(XLEN-1){1'b0}}, lt_u};
                    XOR:     result_o = op1 ^ op2;
                    SR:      result_o = inst_i[30] ? sra_res : srl_res;
                    OR:      result_o = op1 | op2;
                    AND:     result_o = op1 & op2;
                    default: ;
                endcase
            end
            BRANCH: begin
                case (branch_f3_e'(funct3_i))
                    BEQ:     take = eq;
                    BNE:     take = ~eq;
                    BLT:     take = lt_s;
                    BGE:     take = ~lt_s;
                    BLTU:    take = lt_u;
                    BGEU:    take = ~lt_u;
                    default: take = 1'b0;
                endcase
            end
            JAL: begin
                we_o     = 1'b1;
                take     = 1'b1;
                result_o = link_addr;
            end
            JALR: begin
                we_o     = 1'b1;
                take     = 1'b1;
                result_o = link_addr;
                target   = {sum[XLEN-1:1], 1'b0};
            end
            LUI, AUIPC: begin
                we_o     = 1'b1;
                result_o = sum;
            end
            default: ;
        endcase
    end

    assign jump_flag_o = take;
    assign jump_addr_o = take ? target : '0;

endmodule

`default_nettype wire

/* hw/ex_operands.sv */
// field decode, bypass forwarding and operand selection feeding the alu and multiplier
`timescale 1ns/1ns
`default_nettype none

module ex_operands
    import ex_pkg::*;
(
    input  ex_issue_t  issue_i,
    input  bypass_t    bypass_i,
    output opcode_e    opcode_o,
    output logic [2:0] funct3_o,
    output logic       is_mul_o,
    output operands_t  ops_o
);

    logic [XLEN-1:0] inst;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            fwd_rs1;
    logic            fwd_rs2;

    always_comb begin
        inst     = issue_i.inst;
        opcode_o = opcode_e'(inst[6:0]);
        funct3_o = inst[14:12];
        funct7   = inst[31:25];
    end

    always_comb begin
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u = {inst[31:12], 12'b0};
    end

    // x0 is never forwarded
    always_comb begin
        fwd_rs1 = bypass_i.wen && (|bypass_i.waddr) && (bypass_i.waddr == issue_i.rs1_addr);
        fwd_rs2 = bypass_i.wen && (|bypass_i.waddr) && (bypass_i.waddr == issue_i.rs2_addr);
        rs1_val = fwd_rs1 ? bypass_i.wdata : issue_i.rs1_data;
        rs2_val = fwd_rs2 ? bypass_i.wdata : issue_i.rs2_data;
    end

    assign is_mul_o = (opcode_o == OP) && (funct7 == FUNCT7_MULDIV);

    always_comb begin
        ops_o         = '0;
        ops_o.rs1_val = rs1_val;
        ops_o.rs2_val = rs2_val;
        case (opcode_o)
            OP_IMM, JALR: begin
                ops_o.op1 = rs1_val;
                ops_o.op2 = imm_i;
            end
            OP: begin
                ops_o.op1 = rs1_val;
                ops_o.op2 = rs2_val;
            end
            BRANCH: begin
                ops_o.op1 = issue_i.inst_addr;
                ops_o.op2 = imm_b;
            end
            JAL: begin
                ops_o.op1 = issue_i.inst_addr;
                ops_o.op2 = imm_j;
            end
            LUI:   ops_o.op1 = imm_u;  // op2 stays zero
            AUIPC: begin
                ops_o.op1 = issue_i.inst_addr;
                ops_o.op2 = imm_u;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/ex_pkg.sv */
// shared widths, opcode and funct3 encodings and the packed buses of the execute stage
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension marker

    // major opcodes handled by the stage
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SR      = 3'b101,  // srl or sra by bit 30
        OR      = 3'b110,
        AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011
    } mul_f3_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mult_state_e;

    // one decoded instruction with its register reads
    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       inst_addr;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [XLEN-1:0]       rs1_data;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd_addr;
    } ex_issue_t;

    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } bypass_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_t;

    // rs1_val carries forwarded rs1 for branch compares, where op1 is the pc
    typedef struct packed {
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } operands_t;

endpackage

`default_nettype wire
